// ==== hw/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // --------------------
    // geometry
    // --------------------
    localparam int OFFSET_BITS   = 5;
    localparam int INDEX_BITS    = 5;
    localparam int TAG_BITS      = 22;
    localparam int WORD_SEL_BITS = 3;
    localparam int LINE_WORDS    = 8;
    localparam int NUM_SETS      = 32;
    localparam int NUM_WAYS      = 2;

    typedef logic [31:0]              word_t;
    typedef logic [3:0]               strb_t;
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [INDEX_BITS-1:0]    index_t;
    typedef logic [WORD_SEL_BITS-1:0] beat_t;

    // request address, raw or split into cache fields
    typedef union packed {
        word_t raw;
        struct packed {
            tag_t        tag;
            index_t      index;
            beat_t       word;
            logic [1:0]  byte_off;
        } f;
    } cache_addr_u;

    // --------------------
    // cpu port
    // --------------------
    typedef struct packed {
        logic        req;
        logic        wr;
        logic        cacheable;
        cache_addr_u addr;
        word_t       wdata;
        strb_t       sel;
    } cpu_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t rdata;
    } cpu_rsp_t;

    // --------------------
    // memory channels
    // --------------------
    typedef struct packed {
        logic       valid;
        word_t      addr;
        logic [7:0] len;
    } mem_ar_t;

    typedef struct packed {
        logic  valid;
        word_t data;
        logic  last;
    } mem_r_t;

    typedef struct packed {
        logic       valid;
        word_t      addr;
        logic [7:0] len;
    } mem_aw_t;

    typedef struct packed {
        logic  valid;
        word_t data;
        strb_t strb;
        logic  last;
    } mem_w_t;

    typedef struct packed {
        logic valid;
    } mem_b_t;

    typedef enum logic [4:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB_AW,
        S_WB_W,
        S_WB_B,
        S_RF_AR,
        S_RF_R,
        S_UPDATE,
        S_RESP,
        S_UC_AR,
        S_UC_R,
        S_UC_AW,
        S_UC_W,
        S_UC_B
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hw/beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  logic              step,
    output dcache_pkg::beat_t beat,
    output logic              last_beat
);
    import dcache_pkg::*;

    beat_t beat_q;

    // wraps to zero after the eighth beat
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            beat_q <= '0;
        end else if (step) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    assign beat      = beat_q;
    assign last_beat = (beat_q == beat_t'(LINE_WORDS - 1));

    a_no_step_on_clear: assert property (@(posedge clk) disable iff (rst)
        !(step && clear));

endmodule

`default_nettype wire

// ==== hw/tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_store (
    input  logic                    clk,
    input  logic                    rst,
    input  dcache_pkg::cache_addr_u addr,
    input  dcache_pkg::ctrl_state_e state,
    input  logic                    cpu_we,
    input  logic                    upd_line,
    output logic                    hit,
    output logic                    hit_way,
    output logic                    victim_way,
    output logic                    victim_dirty,
    output dcache_pkg::tag_t        victim_tag
);
    import dcache_pkg::*;

    tag_t                               tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0]  valid_q;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0]  dirty_q;
    logic [NUM_SETS-1:0]                lru_q;
    logic [NUM_WAYS-1:0]                hit_raw;
    index_t                             idx;

    assign idx = addr.f.index;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_raw[w] = valid_q[w][idx] && (tag_mem[w][idx] == addr.f.tag);
        end
    end

    assign hit        = |hit_raw;
    assign victim_way = lru_q[idx];
    // on a miss the write target is the victim, which the refill fills
    assign hit_way    = hit_raw[0] ? 1'b0 : (hit_raw[1] ? 1'b1 : victim_way);

    assign victim_dirty = valid_q[victim_way][idx] && dirty_q[victim_way][idx];
    assign victim_tag   = tag_mem[victim_way][idx];

    always_ff @(posedge clk) begin
        if (upd_line) begin
            tag_mem[victim_way][idx] <= addr.f.tag;
        end
    end

    // lru bit names the way to replace next
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (upd_line) begin
            valid_q[victim_way][idx] <= 1'b1;
            dirty_q[victim_way][idx] <= cpu_we;
            lru_q[idx]               <= ~victim_way;
        end else begin
            if (cpu_we) begin
                dirty_q[hit_way][idx] <= 1'b1;
            end
            if (state == S_LOOKUP && hit) begin
                lru_q[idx] <= ~hit_way;
            end
        end
    end

    a_one_hot_hit: assert property (@(posedge clk) disable iff (rst)
        !(hit_raw[0] && hit_raw[1]));

    // a refilled read line is present when the data goes back
    a_refill_hits: assert property (@(posedge clk) disable iff (rst)
        (upd_line && !cpu_we) |=> (hit && state == S_RESP));

endmodule

`default_nettype wire

// ==== hw/data_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_store (
    input  logic                    clk,
    input  dcache_pkg::cache_addr_u addr,
    input  dcache_pkg::beat_t       beat,
    input  logic                    hit_way,
    input  logic                    victim_way,
    input  logic                    fill_we,
    input  logic                    cpu_we,
    input  dcache_pkg::word_t       fill_data,
    input  dcache_pkg::word_t       cpu_data,
    input  dcache_pkg::strb_t       sel,
    output dcache_pkg::word_t       hit_word,
    output dcache_pkg::word_t       victim_word
);
    import dcache_pkg::*;

    word_t  mem [NUM_WAYS][NUM_SETS][LINE_WORDS];
    index_t idx;
    beat_t  word_sel;

    assign idx      = addr.f.index;
    assign word_sel = addr.f.word;

    // --------------------
    // writes
    // --------------------
    always_ff @(posedge clk) begin
        // refill beats land whole
        if (fill_we) begin
            mem[victim_way][idx][beat] <= fill_data;
        end
        // cpu store, byte lanes from sel
        if (cpu_we) begin
            for (int i = 0; i < $bits(strb_t); i++) begin
                if (sel[i]) begin
                    mem[hit_way][idx][word_sel][8*i +: 8] <= cpu_data[8*i +: 8];
                end
            end
        end
    end

    // --------------------
    // reads
    // --------------------
    assign hit_word    = mem[hit_way][idx][word_sel];
    // writeback streams the victim line by beat
    assign victim_word = mem[victim_way][idx][beat];

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  dcache_pkg::cpu_req_t    req,
    input  logic                    hit,
    input  logic                    victim_dirty,
    input  dcache_pkg::word_t       hit_word,
    input  dcache_pkg::beat_t       beat,
    input  logic                    last_beat,
    input  logic                    arready,
    input  logic                    awready,
    input  logic                    wready,
    input  dcache_pkg::mem_r_t      r,
    input  dcache_pkg::mem_b_t      b,
    output dcache_pkg::ctrl_state_e state,
    output logic                    cnt_step,
    output logic                    cnt_clear,
    output logic                    fill_we,
    output logic                    cpu_we,
    output logic                    upd_line,
    output dcache_pkg::cpu_rsp_t    rsp
);
    import dcache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    word_t       rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req.req) begin
                    if (req.cacheable) begin
                        state_d = S_LOOKUP;
                    end else if (req.wr) begin
                        state_d = S_UC_AW;
                    end else begin
                        state_d = S_UC_AR;
                    end
                end
            end
            S_LOOKUP: begin
                if (hit) begin
                    state_d = S_IDLE;
                end else if (victim_dirty) begin
                    state_d = S_WB_AW;
                end else begin
                    state_d = S_RF_AR;
                end
            end
            // --------------------
            // writeback, then refill
            // --------------------
            S_WB_AW:  if (awready) state_d = S_WB_W;
            S_WB_W:   if (wready && last_beat) state_d = S_WB_B;
            S_WB_B:   if (b.valid) state_d = S_RF_AR;
            S_RF_AR:  if (arready) state_d = S_RF_R;
            S_RF_R:   if (r.valid && r.last) state_d = S_UPDATE;
            // write miss finishes here and a read miss answers next cycle
            S_UPDATE: state_d = req.wr ? S_IDLE : S_RESP;
            S_RESP:   state_d = S_IDLE;
            // --------------------
            // uncached single word
            // --------------------
            S_UC_AR:  if (arready) state_d = S_UC_R;
            S_UC_R:   if (r.valid) state_d = S_RESP;
            S_UC_AW:  if (awready) state_d = S_UC_W;
            S_UC_W:   if (wready) state_d = S_UC_B;
            S_UC_B:   if (b.valid) state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    // critical word of a refill, or the single uncached word
    always_ff @(posedge clk) begin
        if (state_q == S_RF_R && r.valid && beat == req.addr.f.word) begin
            rdata_q <= r.data;
        end else if (state_q == S_UC_R && r.valid) begin
            rdata_q <= r.data;
        end
    end

    assign state     = state_q;
    assign cnt_clear = (state_q == S_IDLE);
    assign cnt_step  = (state_q == S_RF_R && r.valid) || (state_q == S_WB_W && wready);
    assign fill_we   = (state_q == S_RF_R) && r.valid;
    assign upd_line  = (state_q == S_UPDATE);
    assign cpu_we    = req.wr && ((state_q == S_LOOKUP && hit) || state_q == S_UPDATE);

    assign rsp.data_ok = (state_q == S_LOOKUP && hit)
                      || (state_q == S_UPDATE && req.wr)
                      || (state_q == S_RESP)
                      || (state_q == S_UC_B && b.valid);
    assign rsp.rdata   = (state_q == S_LOOKUP) ? hit_word : rdata_q;

    a_ok_needs_req: assert property (@(posedge clk) disable iff (rst)
        rsp.data_ok |-> req.req);

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::cpu_req_t cpu_req,
    input  logic                 arready,
    input  logic                 awready,
    input  logic                 wready,
    input  dcache_pkg::mem_r_t   r,
    input  dcache_pkg::mem_b_t   b,
    output dcache_pkg::cpu_rsp_t cpu_rsp,
    output dcache_pkg::mem_ar_t  ar,
    output dcache_pkg::mem_aw_t  aw,
    output dcache_pkg::mem_w_t   w
);
    import dcache_pkg::*;

    ctrl_state_e state;
    logic        cnt_step;
    logic        cnt_clear;
    logic        fill_we;
    logic        cpu_we;
    logic        upd_line;
    logic        hit;
    logic        hit_way;
    logic        victim_way;
    logic        victim_dirty;
    tag_t        victim_tag;
    beat_t       beat;
    logic        last_beat;
    word_t       hit_word;
    word_t       victim_word;
    word_t       line_addr;
    word_t       word_addr;
    word_t       wb_addr;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (cpu_req),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .hit_word     (hit_word),
        .beat         (beat),
        .last_beat    (last_beat),
        .arready      (arready),
        .awready      (awready),
        .wready       (wready),
        .r            (r),
        .b            (b),
        .state        (state),
        .cnt_step     (cnt_step),
        .cnt_clear    (cnt_clear),
        .fill_we      (fill_we),
        .cpu_we       (cpu_we),
        .upd_line     (upd_line),
        .rsp          (cpu_rsp)
    );

    beat_counter u_cnt (
        .clk       (clk),
        .rst       (rst),
        .clear     (cnt_clear),
        .step      (cnt_step),
        .beat      (beat),
        .last_beat (last_beat)
    );

    tag_store u_tags (
        .clk          (clk),
        .rst          (rst),
        .addr         (cpu_req.addr),
        .state        (state),
        .cpu_we       (cpu_we),
        .upd_line     (upd_line),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    data_store u_data (
        .clk         (clk),
        .addr        (cpu_req.addr),
        .beat        (beat),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .fill_we     (fill_we),
        .cpu_we      (cpu_we),
        .fill_data   (r.data),
        .cpu_data    (cpu_req.wdata),
        .sel         (cpu_req.sel),
        .hit_word    (hit_word),
        .victim_word (victim_word)
    );

    // --------------------
    // memory channels
    // --------------------
    assign line_addr = {cpu_req.addr.f.tag, cpu_req.addr.f.index, {OFFSET_BITS{1'b0}}};
    assign word_addr = {cpu_req.addr.raw[31:2], 2'b00};
    // victim line sits in the same set
    assign wb_addr   = {victim_tag, cpu_req.addr.f.index, {OFFSET_BITS{1'b0}}};

    assign ar.valid = (state == S_RF_AR) || (state == S_UC_AR);
    assign ar.addr  = (state == S_RF_AR) ? line_addr : word_addr;
    assign ar.len   = (state == S_RF_AR) ? 8'(LINE_WORDS - 1) : 8'd0;

    assign aw.valid = (state == S_WB_AW) || (state == S_UC_AW);
    assign aw.addr  = (state == S_WB_AW) ? wb_addr : word_addr;
    assign aw.len   = (state == S_WB_AW) ? 8'(LINE_WORDS - 1) : 8'd0;

    assign w.valid  = (state == S_WB_W) || (state == S_UC_W);
    assign w.data   = (state == S_WB_W) ? victim_word : cpu_req.wdata;
    assign w.strb   = (state == S_WB_W) ? 4'hf : cpu_req.sel;
    assign w.last   = (state == S_UC_W) || (state == S_WB_W && last_beat);

endmodule

`default_nettype wire

// ==== tb/dcache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::cpu_req_t cpu_req,
    input  dcache_pkg::cpu_rsp_t cpu_rsp,
    input  dcache_pkg::mem_aw_t  aw,
    input  logic                 awready,
    input  logic                 wb_check,
    input  dcache_pkg::word_t    wb_expect,
    input  int                   test_num,
    output int                   tests,
    output int                   errors
);
    import dcache_pkg::*;

    word_t shadow [word_t];
    word_t last_wb;
    logic  wb_seen;

    // untouched words hold the complement of their address
    function automatic word_t shadow_read(input word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return ~wa;
    endfunction

    task automatic check_response();
        string name;
        word_t exp;
        word_t cur;
        name = $sformatf("req%0d", test_num);
        tests <= tests + 1;
        if (cpu_req.wr) begin
            cur = shadow_read(cpu_req.addr.raw);
            for (int i = 0; i < 4; i++) begin
                if (cpu_req.sel[i]) begin
                    cur[8*i +: 8] = cpu_req.wdata[8*i +: 8];
                end
            end
            shadow[{cpu_req.addr.raw[31:2], 2'b00}] = cur;
            $display("%s write %h done", name, cpu_req.addr.raw);
        end else begin
            exp = shadow_read(cpu_req.addr.raw);
            if (cpu_rsp.rdata !== exp) begin
                $display("MISMATCH %s expected %h actual %h", name, exp, cpu_rsp.rdata);
                errors <= errors + 1;
            end else begin
                $display("%s read %h ok", name, cpu_req.addr.raw);
            end
        end
    endtask

    task automatic check_writeback();
        string name;
        name = $sformatf("req%0d", test_num);
        tests   <= tests + 1;
        wb_seen <= 1'b0;
        if (!wb_seen) begin
            $display("%s expected a line writeback to %h but none was issued", name, wb_expect);
            errors <= errors + 1;
        end else if (last_wb !== wb_expect) begin
            $display("MISMATCH %s expected %h actual %h", name, wb_expect, last_wb);
            errors <= errors + 1;
        end else begin
            $display("%s writeback %h ok", name, last_wb);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            tests   <= 0;
            errors  <= 0;
            wb_seen <= 1'b0;
        end else begin
            if (cpu_rsp.data_ok) begin
                check_response();
            end
            if (wb_check) begin
                check_writeback();
            end
            // writebacks are whole line bursts
            if (aw.valid && awready && aw.len == 8'd7) begin
                last_wb <= aw.addr;
                wb_seen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    logic     clk;
    logic     rst;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    logic     arready = 1'b0;
    logic     awready = 1'b0;
    logic     wready  = 1'b0;
    mem_r_t   r       = '0;
    mem_b_t   b       = '0;
    mem_ar_t  ar;
    mem_aw_t  aw;
    mem_w_t   w;

    logic  wb_check;
    word_t wb_expect;
    int    test_num;
    int    tests;
    int    errors;
    logic  failed;

    // memory slave state
    word_t  mem_words [word_t];
    word_t  rd_addr;
    int     rd_left;
    word_t  wr_addr;
    integer seed = 32'h5697_ec2e;
    integer rnd;

    int               fd;
    int               got_line;
    int               fields;
    logic [8*128-1:0] line_buf;
    logic [31:0]      op;
    logic [31:0]      cacheable;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic [31:0]      sel;

    dcache_top UUT (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .arready (arready),
        .awready (awready),
        .wready  (wready),
        .r       (r),
        .b       (b),
        .cpu_rsp (cpu_rsp),
        .ar      (ar),
        .aw      (aw),
        .w       (w)
    );

    dcache_checker u_chk (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .aw        (aw),
        .awready   (awready),
        .wb_check  (wb_check),
        .wb_expect (wb_expect),
        .test_num  (test_num),
        .tests     (tests),
        .errors    (errors)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // --------------------
    // memory slave
    // --------------------
    function automatic word_t mem_read(input word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        if (mem_words.exists(wa)) begin
            return mem_words[wa];
        end
        return ~wa;
    endfunction

    task automatic mem_write(input word_t a, input word_t data, input strb_t strb);
        word_t cur;
        cur = mem_read(a);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                cur[8*i +: 8] = data[8*i +: 8];
            end
        end
        mem_words[{a[31:2], 2'b00}] = cur;
    endtask

    always @(posedge clk) begin
        rnd = $random(seed);
        arready <= rnd[0];
        awready <= rnd[1];
        wready  <= rnd[2];
    end

    // read bursts return one beat per cycle in address order
    always @(posedge clk) begin
        if (rst) begin
            r       <= '0;
            rd_left <= 0;
        end else if (rd_left != 0) begin
            r.valid <= 1'b1;
            r.data  <= mem_read(rd_addr);
            r.last  <= (rd_left == 1);
            rd_addr <= rd_addr + 32'd4;
            rd_left <= rd_left - 1;
        end else begin
            r <= '0;
            if (ar.valid && arready) begin
                rd_addr <= ar.addr;
                rd_left <= int'(ar.len) + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            b <= '0;
        end else begin
            b.valid <= 1'b0;
            if (aw.valid && awready) begin
                wr_addr <= aw.addr;
            end
            if (w.valid && wready) begin
                mem_write(wr_addr, w.data, w.strb);
                wr_addr <= wr_addr + 32'd4;
                if (w.last) begin
                    b.valid <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------
    task automatic run_request(input logic wr, input logic cache_en, input word_t a,
                               input word_t data, input strb_t strb);
        cpu_req_t nxt;
        int       waited;
        logic     got;
        nxt.req       = 1'b1;
        nxt.wr        = wr;
        nxt.cacheable = cache_en;
        nxt.addr.raw  = a;
        nxt.wdata     = data;
        nxt.sel       = strb;
        @(posedge clk);
        test_num <= test_num + 1;
        cpu_req  <= nxt;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < 200) begin
            @(posedge clk);
            got = cpu_rsp.data_ok;
            waited++;
        end
        cpu_req.req <= 1'b0;
        if (!got) begin
            $display("timeout: req%0d got no data_ok within 200 cycles", test_num);
            failed = 1'b1;
        end
    endtask

    task automatic run_wb_check(input word_t a);
        @(posedge clk);
        test_num  <= test_num + 1;
        wb_expect <= a;
        wb_check  <= 1'b1;
        @(posedge clk);
        wb_check  <= 1'b0;
    endtask

    initial begin
        rst       = 1'b1;
        cpu_req   = '0;
        wb_check  = 1'b0;
        wb_expect = '0;
        test_num  = 0;
        failed    = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("tb/dcache_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/dcache_testdata.txt");
            failed = 1'b1;
        end else begin
            while (!$feof(fd) && !failed) begin
                got_line = $fgets(line_buf, fd);
                fields   = 0;
                if (got_line != 0) begin
                    fields = $sscanf(line_buf, "%h %h %h %h %h",
                                     op, cacheable, addr, wdata, sel);
                end
                // comment and blank lines parse to fewer fields
                if (fields == 5) begin
                    if (op == 32'd2) begin
                        run_wb_check(addr);
                    end else begin
                        run_request(op[0], cacheable[0], addr, wdata, sel[3:0]);
                    end
                end
            end
            $fclose(fd);
        end

        repeat (2) @(posedge clk);
        $display("tests: %0d, errors: %0d", tests, errors);
        if (errors == 0 && !failed) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/dcache_testdata.txt ====
# op: 0 read, 1 write, 2 expect last line writeback at addr
# op cacheable addr wdata sel (all hex)
0 1 00001044 00000000 0
0 1 00001048 00000000 0
1 1 00001048 aabbccdd 3
0 1 00001048 00000000 0
1 1 00002010 12345678 6
0 1 00002010 00000000 0
1 1 00003068 11111111 f
1 1 00003468 22222222 f
1 1 00003868 33333333 f
2 1 00003060 00000000 0
0 1 00003068 00000000 0
2 1 00003460 00000000 0
1 1 000040a4 44444444 f
1 1 000044a4 55555555 f
0 1 000040a4 00000000 0
0 1 000048a4 00000000 0
2 1 000044a0 00000000 0
1 0 80000010 deadbeef f
0 0 80000010 00000000 0
1 0 80000024 cafef00d 9
0 0 80000024 00000000 0
0 0 80000030 00000000 0

// ==== tb.f ====
hw/dcache_pkg.sv
hw/beat_counter.sv
hw/tag_store.sv
hw/data_store.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tb/dcache_checker.sv
tb/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - hw/dcache_pkg.sv
      - hw/beat_counter.sv
      - hw/tag_store.sv
      - hw/data_store.sv
      - hw/dcache_ctrl.sv
      - hw/dcache_top.sv
  - target: test
    files:
      - tb/dcache_checker.sv
      - tb/tb_dcache.sv
